/* pmp_cfg.svh */
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// csr data width of rv32.
`define PMP_XLEN 32

// number of protection entries.
`define PMP_ENTRIES 16

// physical address width; the stored address keeps two bits less.
`define PMP_PADDR_LEN 32

// first configuration csr and first address csr.
`define PMP_CFG_BASE 12'h3A0
`define PMP_ADDR_BASE 12'h3B0

// field positions inside one configuration byte.
`define PMP_CFG_R_BIT 0
`define PMP_CFG_W_BIT 1
`define PMP_CFG_X_BIT 2
`define PMP_CFG_A_LSB 3
`define PMP_CFG_L_BIT 7

// address mode codes.
`define PMP_MODE_OFF 2'd0
`define PMP_MODE_TOR 2'd1
`define PMP_MODE_NAPOT 2'd3

`endif

/* logic/pmp_pkg.sv */
`include "pmp_cfg.svh"

package pmp_pkg;

    // one csr data word.
    typedef logic [`PMP_XLEN-1:0] xlen_t;

    // csr address.
    typedef logic [11:0] csr_addr_t;

    // configuration byte of one entry.
    typedef logic [7:0] pmp_cfg_t;

    // address-mode field.
    typedef logic [1:0] pmp_mode_t;

    // entry index.
    typedef logic [3:0] pmp_idx_t;

    // set bits go in first, then clear bits come out.
    function automatic xlen_t csr_merge(
        input xlen_t old_val,
        input xlen_t set_mask,
        input xlen_t clr_mask
    );
        xlen_t merged;
        merged = (old_val | set_mask) & ~clr_mask;
        return merged;
    endfunction

endpackage

/* logic/pmp_cfg_regs.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_cfg_regs
    import pmp_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  xlen_t     csr_sdata,
    input  xlen_t     csr_cdata,
    output pmp_cfg_t  pmpcfg [`PMP_ENTRIES]
);

    logic       cfg_hit;
    logic [1:0] grp;
    pmp_idx_t   entry_idx [4];
    xlen_t      old_word;
    xlen_t      new_word;
    pmp_cfg_t   raw_byte [4];
    pmp_cfg_t   new_byte [4];

    // pmpcfg0..3 share the upper ten address bits.
    assign cfg_hit = csr_wr && (csr_waddr[11:2] == 10'(`PMP_CFG_BASE >> 2));
    assign grp     = csr_waddr[1:0];

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            entry_idx[j]       = {grp, 2'(j)};
            old_word[j*8 +: 8] = pmpcfg[entry_idx[j]];
        end
        new_word = csr_merge(old_word, csr_sdata, csr_cdata);
        for (int j = 0; j < 4; j++) begin
            raw_byte[j] = new_word[j*8 +: 8];
            // reserved bits stay zero.
            new_byte[j] = '0;
            new_byte[j][`PMP_CFG_R_BIT] = raw_byte[j][`PMP_CFG_R_BIT];
            // w without r is not a legal combination.
            new_byte[j][`PMP_CFG_W_BIT] = raw_byte[j][`PMP_CFG_W_BIT] &
                                          raw_byte[j][`PMP_CFG_R_BIT];
            new_byte[j][`PMP_CFG_X_BIT] = raw_byte[j][`PMP_CFG_X_BIT];
            new_byte[j][`PMP_CFG_A_LSB +: 2] = raw_byte[j][`PMP_CFG_A_LSB +: 2];
            new_byte[j][`PMP_CFG_L_BIT] = raw_byte[j][`PMP_CFG_L_BIT];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                pmpcfg[i] <= '0;
            end
        end else if (cfg_hit) begin
            for (int j = 0; j < 4; j++) begin
                // a locked byte holds until reset.
                if (!pmpcfg[entry_idx[j]][`PMP_CFG_L_BIT]) begin
                    pmpcfg[entry_idx[j]] <= new_byte[j];
                end
            end
        end
    end

endmodule

/* logic/pmp_addr_regs.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_addr_regs
    import pmp_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  xlen_t     csr_sdata,
    input  xlen_t     csr_cdata,
    input  pmp_cfg_t  pmpcfg  [`PMP_ENTRIES],
    output xlen_t     pmpaddr [`PMP_ENTRIES]
);

    logic                    addr_hit;
    pmp_idx_t                widx;
    xlen_t                   merged;
    xlen_t                   new_addr;
    pmp_mode_t               next_mode [`PMP_ENTRIES-1];
    logic [`PMP_ENTRIES-1:0] frozen;

    // pmpaddr0..15 share the upper eight address bits.
    assign addr_hit = csr_wr && (csr_waddr[11:4] == 8'(`PMP_ADDR_BASE >> 4));
    assign widx     = csr_waddr[3:0];
    assign merged   = csr_merge(pmpaddr[widx], csr_sdata, csr_cdata);

    // keep only the bits a 32-bit physical address needs.
    assign new_addr = {{(`PMP_XLEN - `PMP_PADDR_LEN + 2){1'b0}},
                       merged[`PMP_PADDR_LEN-3:0]};

    always_comb begin
        for (int i = 0; i < `PMP_ENTRIES - 1; i++) begin
            next_mode[i] = pmpcfg[i+1][`PMP_CFG_A_LSB +: 2];
            // a locked tor entry above also pins this address.
            frozen[i] = pmpcfg[i][`PMP_CFG_L_BIT] ||
                        (pmpcfg[i+1][`PMP_CFG_L_BIT] && next_mode[i] == `PMP_MODE_TOR);
        end
        frozen[`PMP_ENTRIES-1] = pmpcfg[`PMP_ENTRIES-1][`PMP_CFG_L_BIT];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                pmpaddr[i] <= '0;
            end
        end else if (addr_hit && !frozen[widx]) begin
            pmpaddr[widx] <= new_addr;
        end
    end

endmodule

/* logic/pmp_csr_read.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_csr_read
    import pmp_pkg::*;
(
    input  csr_addr_t csr_raddr,
    input  pmp_cfg_t  pmpcfg  [`PMP_ENTRIES],
    input  xlen_t     pmpaddr [`PMP_ENTRIES],
    output xlen_t     csr_rdata
);

    logic      cfg_sel;
    logic      addr_sel;
    pmp_idx_t  rd_idx;
    pmp_mode_t rd_mode;
    xlen_t     rd_addr;
    xlen_t     trail_ones;

    assign cfg_sel  = csr_raddr[11:2] == 10'(`PMP_CFG_BASE >> 2);
    assign addr_sel = csr_raddr[11:4] == 8'(`PMP_ADDR_BASE >> 4);
    assign rd_idx   = csr_raddr[3:0];
    assign rd_mode  = pmpcfg[rd_idx][`PMP_CFG_A_LSB +: 2];
    assign rd_addr  = pmpaddr[rd_idx];

    // ones below the lowest zero bit.
    assign trail_ones = rd_addr & ~(rd_addr + xlen_t'(1));

    always_comb begin
        csr_rdata = '0;
        if (cfg_sel) begin
            // lowest entry sits in the low byte.
            for (int j = 0; j < 4; j++) begin
                csr_rdata[j*8 +: 8] = pmpcfg[{csr_raddr[1:0], 2'(j)}];
            end
        end else if (addr_sel) begin
            if (rd_mode[1]) begin
                csr_rdata = rd_addr;
            end else begin
                // off and tor hide the napot size bits.
                csr_rdata = rd_addr & ~trail_ones;
            end
        end
    end

endmodule

/* logic/pmp_csr.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_csr
    import pmp_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  csr_addr_t csr_raddr,
    input  xlen_t     csr_sdata,
    input  xlen_t     csr_cdata,
    output xlen_t     csr_rdata,
    output pmp_cfg_t  pmpcfg  [`PMP_ENTRIES],
    output xlen_t     pmpaddr [`PMP_ENTRIES]
);

    // configuration bytes also feed the address locks.
    pmp_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .csr_sdata (csr_sdata),
        .csr_cdata (csr_cdata),
        .pmpcfg    (pmpcfg)
    );

    pmp_addr_regs u_addr_regs (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .csr_sdata (csr_sdata),
        .csr_cdata (csr_cdata),
        .pmpcfg    (pmpcfg),
        .pmpaddr   (pmpaddr)
    );

    // read path has no register stage.
    pmp_csr_read u_csr_read (
        .csr_raddr (csr_raddr),
        .pmpcfg    (pmpcfg),
        .pmpaddr   (pmpaddr),
        .csr_rdata (csr_rdata)
    );

endmodule

/* test/pmp_csr_props.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_csr_props
    import pmp_pkg::*;
(
    input logic     clk,
    input logic     rstn,
    input pmp_cfg_t pmpcfg  [`PMP_ENTRIES],
    input xlen_t    pmpaddr [`PMP_ENTRIES]
);

    for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_entry

        // write access is only legal together with read access.
        a_w_needs_r: assert property (
            @(posedge clk) disable iff (!rstn)
            pmpcfg[i][`PMP_CFG_W_BIT] |-> pmpcfg[i][`PMP_CFG_R_BIT]
        ) else $error("entry %0d has write enabled without read", i);

        // the two bits between the mode field and the lock bit.
        a_reserved_zero: assert property (
            @(posedge clk) disable iff (!rstn)
            pmpcfg[i][`PMP_CFG_L_BIT-1 -: 2] == 2'b00
        ) else $error("entry %0d has a reserved configuration bit set", i);

        a_addr_top_zero: assert property (
            @(posedge clk) disable iff (!rstn)
            pmpaddr[i][`PMP_XLEN-1 -: 2] == 2'b00
        ) else $error("address %0d holds bits above the physical address range", i);

        // once locked, the byte holds until reset.
        a_lock_holds: assert property (
            @(posedge clk) disable iff (!rstn)
            $past(pmpcfg[i][`PMP_CFG_L_BIT]) |-> pmpcfg[i] == $past(pmpcfg[i])
        ) else $error("locked configuration byte %0d changed", i);

    end

endmodule

bind pmp_csr pmp_csr_props u_props (
    .clk     (clk),
    .rstn    (rstn),
    .pmpcfg  (pmpcfg),
    .pmpaddr (pmpaddr)
);

/* test/pmp_csr_tb.sv */
`timescale 1ns/1ps

`include "pmp_cfg.svh"

module pmp_csr_tb
    import pmp_pkg::*;
();

    localparam int TEST_CYCLES = 500;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;
    localparam logic [31:0] SEED = 32'h534f87ec;
    // 30 bits of a 32-bit physical address.
    localparam xlen_t ADDR_MASK = 32'h3fff_ffff;

    logic      clk = 1'b0;
    logic      rstn;
    logic      csr_wr;
    csr_addr_t csr_waddr;
    csr_addr_t csr_raddr;
    xlen_t     csr_sdata;
    xlen_t     csr_cdata;
    xlen_t     csr_rdata;
    pmp_cfg_t  pmpcfg  [`PMP_ENTRIES];
    xlen_t     pmpaddr [`PMP_ENTRIES];

    pmp_cfg_t  model_cfg  [`PMP_ENTRIES];
    xlen_t     model_addr [`PMP_ENTRIES];
    int        errors;

    pmp_csr u_pmp_csr (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .csr_raddr (csr_raddr),
        .csr_sdata (csr_sdata),
        .csr_cdata (csr_cdata),
        .csr_rdata (csr_rdata),
        .pmpcfg    (pmpcfg),
        .pmpaddr   (pmpaddr)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic pmp_cfg_t cfg_byte(input logic lock, input pmp_mode_t mode,
                                          input logic [2:0] perms);
        pmp_cfg_t b;
        b = '0;
        b[2:0] = perms;
        b[`PMP_CFG_A_LSB +: 2] = mode;
        b[`PMP_CFG_L_BIT] = lock;
        return b;
    endfunction

    // reserved bits drop, and W survives only with R.
    function automatic pmp_cfg_t legal_cfg_byte(input pmp_cfg_t b);
        pmp_cfg_t r;
        r = b & 8'h9f;
        if (!r[`PMP_CFG_R_BIT]) begin
            r[`PMP_CFG_W_BIT] = 1'b0;
        end
        return r;
    endfunction

    function automatic logic addr_frozen(input int i);
        logic f;
        f = model_cfg[i][`PMP_CFG_L_BIT];
        if (i < `PMP_ENTRIES - 1) begin
            if (model_cfg[i+1][`PMP_CFG_L_BIT] &&
                model_cfg[i+1][`PMP_CFG_A_LSB +: 2] == `PMP_MODE_TOR) begin
                f = 1'b1;
            end
        end
        return f;
    endfunction

    function automatic void update_model(input csr_addr_t a, input xlen_t s, input xlen_t c);
        int    base;
        xlen_t old_word;
        xlen_t new_word;
        if (a >= `PMP_CFG_BASE && a <= `PMP_CFG_BASE + 12'd3) begin
            base = 4 * int'(a - `PMP_CFG_BASE);
            for (int j = 0; j < 4; j++) begin
                old_word[j*8 +: 8] = model_cfg[base + j];
            end
            new_word = (old_word | s) & ~c;
            for (int j = 0; j < 4; j++) begin
                if (!model_cfg[base + j][`PMP_CFG_L_BIT]) begin
                    model_cfg[base + j] = legal_cfg_byte(new_word[j*8 +: 8]);
                end
            end
        end else if (a >= `PMP_ADDR_BASE && a <= `PMP_ADDR_BASE + 12'd15) begin
            base = int'(a - `PMP_ADDR_BASE);
            if (!addr_frozen(base)) begin
                model_addr[base] = ((model_addr[base] | s) & ~c) & ADDR_MASK;
            end
        end
    endfunction

    function automatic xlen_t expected_read(input csr_addr_t a);
        xlen_t v;
        int    idx;
        int    b;
        v = '0;
        if (a >= `PMP_CFG_BASE && a <= `PMP_CFG_BASE + 12'd3) begin
            idx = 4 * int'(a - `PMP_CFG_BASE);
            for (int j = 0; j < 4; j++) begin
                v[j*8 +: 8] = model_cfg[idx + j];
            end
        end else if (a >= `PMP_ADDR_BASE && a <= `PMP_ADDR_BASE + 12'd15) begin
            idx = int'(a - `PMP_ADDR_BASE);
            v = model_addr[idx];
            // off and tor read with the trailing ones cleared.
            if (!model_cfg[idx][`PMP_CFG_A_LSB + 1]) begin
                b = 0;
                while (b < `PMP_XLEN && v[b]) begin
                    v[b] = 1'b0;
                    b++;
                end
            end
        end
        return v;
    endfunction

    task automatic write_csr(input csr_addr_t a, input xlen_t s, input xlen_t c);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_waddr <= a;
        csr_sdata <= s;
        csr_cdata <= c;
        @(posedge clk);
        csr_wr    <= 1'b0;
        update_model(a, s, c);
    endtask

    task automatic write_cfg_byte(input int e, input pmp_cfg_t value);
        int       sh;
        pmp_cfg_t inv;
        xlen_t    s;
        xlen_t    c;
        sh = 8 * (e % 4);
        inv = ~value;
        s = xlen_t'(value) << sh;
        c = xlen_t'(inv) << sh;
        write_csr(`PMP_CFG_BASE + csr_addr_t'(e / 4), s, c);
    endtask

    task automatic read_csr(input csr_addr_t a, output xlen_t d);
        @(posedge clk);
        csr_raddr <= a;
        @(negedge clk);
        d = csr_rdata;
    endtask

    // the raw register outputs go to the address checker elsewhere in the core.
    task automatic check_outputs();
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            assert (pmpcfg[i] == model_cfg[i]) else begin
                errors++;
                abort_run($sformatf("mismatch at %0t ns: pmpcfg[%0d] is 0x%02h, expected 0x%02h",
                                    $time, i, pmpcfg[i], model_cfg[i]));
            end
            assert (pmpaddr[i] == model_addr[i]) else begin
                errors++;
                abort_run($sformatf("mismatch at %0t ns: pmpaddr[%0d] is 0x%08h, expected 0x%08h",
                                    $time, i, pmpaddr[i], model_addr[i]));
            end
        end
    endtask

    task automatic check_read(input csr_addr_t a);
        xlen_t got;
        xlen_t exp;
        read_csr(a, got);
        exp = expected_read(a);
        assert (got == exp) else begin
            errors++;
            abort_run($sformatf("mismatch at %0t ns: csr 0x%03h read 0x%08h, expected 0x%08h",
                                $time, a, got, exp));
        end
        check_outputs();
    endtask

    task automatic check_all();
        for (int g = 0; g < 4; g++) begin
            check_read(`PMP_CFG_BASE + csr_addr_t'(g));
        end
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            check_read(`PMP_ADDR_BASE + csr_addr_t'(i));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: the test did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        int        g;
        int        e;
        xlen_t     v;
        pmp_mode_t mode;
        void'($urandom(SEED));
        errors = 0;
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            model_cfg[i]  = '0;
            model_addr[i] = '0;
        end
        rstn      <= 1'b0;
        csr_wr    <= 1'b0;
        csr_waddr <= '0;
        csr_raddr <= '0;
        csr_sdata <= '0;
        csr_cdata <= '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        // every csr reads zero after reset and so do unmapped addresses.
        check_all();
        check_read(12'h3C0);
        check_read(12'h3A4);

        // random merges on configuration csrs keep the lock bits clear.
        for (int n = 0; n < 40; n++) begin
            g = $urandom_range(3, 0);
            write_csr(`PMP_CFG_BASE + csr_addr_t'(g), $urandom & ~32'h8080_8080, $urandom);
            check_read(`PMP_CFG_BASE + csr_addr_t'(g));
        end

        for (int n = 0; n < 4; n++) begin
            write_csr(`PMP_CFG_BASE + csr_addr_t'(n), '0, 32'hffff_ffff);
        end
        // address writes under off, tor and napot modes.
        for (int n = 0; n < 24; n++) begin
            e = $urandom_range(15, 0);
            mode = (n % 3 == 0) ? `PMP_MODE_OFF :
                   (n % 3 == 1) ? `PMP_MODE_TOR : `PMP_MODE_NAPOT;
            write_cfg_byte(e, cfg_byte(1'b0, mode, 3'b011));
            v = ($urandom << 8) | (32'h0000_00ff >> (n % 8));
            write_csr(`PMP_ADDR_BASE + csr_addr_t'(e), v, ~v);
            check_read(`PMP_ADDR_BASE + csr_addr_t'(e));
            write_csr(`PMP_ADDR_BASE + csr_addr_t'(e), $urandom, $urandom);
            check_read(`PMP_ADDR_BASE + csr_addr_t'(e));
        end
        check_all();

        // entry 5 locked in napot mode.
        write_cfg_byte(5, cfg_byte(1'b1, `PMP_MODE_NAPOT, 3'b101));
        check_read(`PMP_CFG_BASE + 12'd1);
        write_csr(`PMP_CFG_BASE + 12'd1, 32'h0d0d_0d0d, 32'h0000_f000);
        check_read(`PMP_CFG_BASE + 12'd1);
        for (int n = 0; n < 6; n++) begin
            write_csr(`PMP_CFG_BASE + 12'd1, $urandom & ~32'h8080_8080, $urandom);
            check_read(`PMP_CFG_BASE + 12'd1);
        end
        for (int n = 0; n < 4; n++) begin
            write_csr(`PMP_ADDR_BASE + 12'd5, $urandom, $urandom);
            check_read(`PMP_ADDR_BASE + 12'd5);
            write_csr(`PMP_ADDR_BASE + 12'd4, $urandom, $urandom);
            check_read(`PMP_ADDR_BASE + 12'd4);
        end

        // tor locks on entries 10 and 15 pin the address below them.
        v = $urandom;
        write_csr(`PMP_ADDR_BASE + 12'd9, v, ~v);
        write_cfg_byte(10, cfg_byte(1'b1, `PMP_MODE_TOR, 3'b001));
        write_cfg_byte(15, cfg_byte(1'b1, `PMP_MODE_TOR, 3'b011));
        for (int n = 0; n < 4; n++) begin
            for (int i = 9; i < `PMP_ENTRIES; i++) begin
                write_csr(`PMP_ADDR_BASE + csr_addr_t'(i), $urandom, $urandom);
                check_read(`PMP_ADDR_BASE + csr_addr_t'(i));
            end
        end
        check_all();

        // unmapped addresses whose low bits match registers that now hold data.
        check_read(12'h3C9);
        check_read(12'h3A5);

        if (errors == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d checks failed", errors));
        end
    end

endmodule

/* sources.f */
+incdir+.
logic/pmp_pkg.sv
logic/pmp_cfg_regs.sv
logic/pmp_addr_regs.sv
logic/pmp_csr_read.sv
logic/pmp_csr.sv
test/pmp_csr_props.sv
test/pmp_csr_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the pmp csr testbench with verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f sources.f --top-module pmp_csr_tb \
    -Mdir "$build_dir" -o pmp_csr_sim > "$build_log" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $build_status"
    exit 1
fi

"./$build_dir/pmp_csr_sim" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "test failed" "$sim_log"; then
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "test passed" "$sim_log"; then
    echo "no verdict found in $sim_log"
    exit 1
fi
exit 0
